// File: source/phy_cfg_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY datapath configuration
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package phy_cfg_pkg;

	// DQS groups and their widths
	localparam int NUM_GROUPS   = 2;
	localparam int DQ_PER_GROUP = 8;
	localparam int DM_PER_GROUP = 1;

	// Half rate gives four data slots and two enable phases per AFI cycle
	localparam int NUM_SLOTS      = 4;
	localparam int NUM_PHASES     = 2;
	localparam int AFI_RATE_RATIO = 2;

	// Read latency setting from the sequencer
	localparam int LAT_WIDTH = 5;

	// Per-group VFIFO offset, saturating at its all-ones value
	localparam int VFIFO_OFS_WIDTH = 3;

	// Covers the extra shift plus the largest latency and offset
	localparam int DELAY_DEPTH = 40;

	// Flattened AFI write bus widths
	localparam int AFI_DQ_WIDTH = NUM_SLOTS * NUM_GROUPS * DQ_PER_GROUP;
	localparam int AFI_DM_WIDTH = NUM_SLOTS * NUM_GROUPS * DM_PER_GROUP;
	localparam int AFI_EN_WIDTH = NUM_PHASES * NUM_GROUPS;

endpackage

// File: source/phy_types_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY datapath bus types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package phy_types_pkg;

	import phy_cfg_pkg::*;

	// AFI write bus, ordered by time slot and then by DQS group
	// Slot 0 of group 0 sits in the lowest bits
	typedef struct packed {
		logic [AFI_DQ_WIDTH-1:0] dq;
		logic [AFI_DM_WIDTH-1:0] wrdata_mask;
		logic [AFI_EN_WIDTH-1:0] wrdata_en;
		logic [AFI_EN_WIDTH-1:0] dqs_en;
		logic [AFI_EN_WIDTH-1:0] oct_ena;
	} afi_write_t;

	// Write lane of a single DQS group
	typedef struct packed {
		logic [NUM_SLOTS-1:0][DQ_PER_GROUP-1:0]  dq_slots;
		logic [NUM_SLOTS-1:0][DM_PER_GROUP-1:0]  dm_slots;
		logic [NUM_PHASES-1:0][DQ_PER_GROUP-1:0] oe;
		logic [NUM_PHASES-1:0]                   dqs_en;
		logic [NUM_PHASES-1:0]                   oct_ena;
	} group_write_t;

	// Read controls from the sequencer
	typedef struct packed {
		logic [LAT_WIDTH-1:0]  latency;
		logic [NUM_GROUPS-1:0] inc_vfifo;
	} read_ctrl_t;

endpackage

// File: source/write_lane_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write lane regrouping
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module write_lane_decode #(
	parameter int REGISTER_C2P = 1
) (
	input  logic                      pll_afi_clk,
	input  logic                      reset_n_afi_clk,
	input  phy_types_pkg::afi_write_t afi_write,
	output phy_types_pkg::group_write_t [phy_cfg_pkg::NUM_GROUPS-1:0] write_lanes
);

	import phy_cfg_pkg::*;
	import phy_types_pkg::*;

	afi_write_t write_bus;

	// Optional core-to-periphery register on the whole bus
	generate
		if (REGISTER_C2P != 0) begin : g_c2p_reg
			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
				if (!reset_n_afi_clk) begin
					write_bus <= '0;
				end else begin
					write_bus <= afi_write;
				end
			end
		end else begin : g_c2p_bypass
			assign write_bus = afi_write;
		end
	endgenerate

	// The AFI bus is slot-major: slice s of group g sits at index s * NUM_GROUPS + g
	always_comb begin
		int slice;

		for (int g = 0; g < NUM_GROUPS; g++) begin
			for (int s = 0; s < NUM_SLOTS; s++) begin
				slice = s * NUM_GROUPS + g;
				write_lanes[g].dq_slots[s] =
					write_bus.dq[slice*DQ_PER_GROUP +: DQ_PER_GROUP];
				write_lanes[g].dm_slots[s] =
					write_bus.wrdata_mask[slice*DM_PER_GROUP +: DM_PER_GROUP];
			end

			// Enables use the same phase-major order, one bit per group
			for (int p = 0; p < NUM_PHASES; p++) begin
				slice = p * NUM_GROUPS + g;
				write_lanes[g].oe[p]      = {DQ_PER_GROUP{write_bus.wrdata_en[slice]}};
				write_lanes[g].dqs_en[p]  = write_bus.dqs_en[slice];
				write_lanes[g].oct_ena[p] = write_bus.oct_ena[slice];
			end
		end
	end

endmodule

// File: source/read_valid_delay.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read valid latency and VFIFO delay
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module read_valid_delay #(
	parameter int EXTRA_VFIFO_SHIFT = 0
) (
	input  logic                                pll_afi_clk,
	input  logic                                reset_n_afi_clk,
	input  logic                                rdata_en_full,
	input  phy_types_pkg::read_ctrl_t           read_ctrl,
	input  logic                                mem_stable,
	output logic [phy_cfg_pkg::NUM_GROUPS-1:0]  group_valid
);

	import phy_cfg_pkg::*;

	localparam int TAP_WIDTH = $clog2(DELAY_DEPTH);
	localparam logic [VFIFO_OFS_WIDTH-1:0] OFS_MAX = '1;

	logic                                             rdata_en_shifted;
	logic [NUM_GROUPS-1:0][VFIFO_OFS_WIDTH-1:0]       vfifo_ofs;
	logic [NUM_GROUPS-1:0][DELAY_DEPTH-1:0]           delay_line;
	logic [NUM_GROUPS-1:0][TAP_WIDTH-1:0]             tap;

	// Fixed extra shift of the read-enable strobe
	generate
		if (EXTRA_VFIFO_SHIFT == 0) begin : g_no_shift
			assign rdata_en_shifted = rdata_en_full;
		end else begin : g_shift
			logic [EXTRA_VFIFO_SHIFT-1:0] shift_q;

			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
				if (!reset_n_afi_clk) begin
					shift_q <= '0;
				end else begin
					shift_q[0] <= rdata_en_full;
					for (int k = 1; k < EXTRA_VFIFO_SHIFT; k++) begin
						shift_q[k] <= shift_q[k-1];
					end
				end
			end

			assign rdata_en_shifted = shift_q[EXTRA_VFIFO_SHIFT-1];
		end
	endgenerate

	// VFIFO offsets stay at zero until the memory interface is stable
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			vfifo_ofs <= '0;
		end else if (!mem_stable) begin
			vfifo_ofs <= '0;
		end else begin
			for (int g = 0; g < NUM_GROUPS; g++) begin
				if (read_ctrl.inc_vfifo[g] && vfifo_ofs[g] != OFS_MAX) begin
					vfifo_ofs[g] <= vfifo_ofs[g] + 1'b1;
				end
			end
		end
	end

	// One delay line per group, several strobes may be in flight
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			delay_line <= '0;
		end else begin
			for (int g = 0; g < NUM_GROUPS; g++) begin
				delay_line[g] <= {delay_line[g][DELAY_DEPTH-2:0], rdata_en_shifted};
			end
		end
	end

	// Tap k holds the shifted strobe from k + 1 cycles ago
	always_comb begin
		for (int g = 0; g < NUM_GROUPS; g++) begin
			tap[g] = TAP_WIDTH'(read_ctrl.latency) + TAP_WIDTH'(vfifo_ofs[g]);
			group_valid[g] = delay_line[g][tap[g]];
		end
	end

endmodule

// File: source/read_valid_merge.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read valid merge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module read_valid_merge (
	input  logic                                    pll_afi_clk,
	input  logic                                    reset_n_afi_clk,
	input  logic [phy_cfg_pkg::NUM_GROUPS-1:0]      group_valid,
	output logic [phy_cfg_pkg::AFI_RATE_RATIO-1:0]  afi_rdata_valid
);

	import phy_cfg_pkg::*;

	logic all_groups_valid;

	// The read is only valid once every group has aligned
	assign all_groups_valid = &group_valid;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid <= '0;
		end else begin
			afi_rdata_valid <= {AFI_RATE_RATIO{all_groups_valid}};
		end
	end

endmodule

// File: source/io_datapath_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DDR3 I/O core datapath
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module io_datapath_top #(
	parameter int REGISTER_C2P      = 1,
	parameter int EXTRA_VFIFO_SHIFT = 1
) (
	input  logic                                    pll_afi_clk,
	input  logic                                    reset_n_afi_clk,
	input  phy_types_pkg::afi_write_t               afi_write,
	input  logic                                    rdata_en_full,
	input  phy_types_pkg::read_ctrl_t               read_ctrl,
	input  logic                                    mem_stable,
	output phy_types_pkg::group_write_t [phy_cfg_pkg::NUM_GROUPS-1:0] write_lanes,
	output logic [phy_cfg_pkg::AFI_RATE_RATIO-1:0]  afi_rdata_valid
);

	import phy_cfg_pkg::*;

	logic [NUM_GROUPS-1:0] group_valid;

	write_lane_decode #(
		.REGISTER_C2P (REGISTER_C2P)
	) decode_i (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_write       (afi_write),
		.write_lanes     (write_lanes)
	);

	// Read path: strobe delay per group, then merge across groups
	read_valid_delay #(
		.EXTRA_VFIFO_SHIFT (EXTRA_VFIFO_SHIFT)
	) delay_i (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_full   (rdata_en_full),
		.read_ctrl       (read_ctrl),
		.mem_stable      (mem_stable),
		.group_valid     (group_valid)
	);

	read_valid_merge merge_i (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.group_valid     (group_valid),
		.afi_rdata_valid (afi_rdata_valid)
	);

endmodule

// File: sim/io_datapath_properties.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O datapath properties
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module io_datapath_properties (
	input logic                                      pll_afi_clk,
	input logic                                      reset_n_afi_clk,
	input logic                                      mem_stable,
	input logic [phy_cfg_pkg::AFI_RATE_RATIO-1:0]    afi_rdata_valid,
	input logic [phy_cfg_pkg::NUM_GROUPS-1:0][phy_cfg_pkg::VFIFO_OFS_WIDTH-1:0] vfifo_ofs
);

	import phy_cfg_pkg::*;

	localparam logic [VFIFO_OFS_WIDTH-1:0] OFS_MAX = '1;

	reset_clear: assert property (@(posedge pll_afi_clk)
		!reset_n_afi_clk |-> afi_rdata_valid == '0)
		else $error("afi_rdata_valid is not zero during reset");

	// All rate bits carry the same merged valid
	rate_bits_equal: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(&afi_rdata_valid) || !(|afi_rdata_valid))
		else $error("afi_rdata_valid bits differ: %b", afi_rdata_valid);

	generate
		for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_ofs
			ofs_saturates: assert property (@(posedge pll_afi_clk)
				disable iff (!reset_n_afi_clk)
				(vfifo_ofs[g] == OFS_MAX && mem_stable) |=> vfifo_ofs[g] == OFS_MAX)
				else $error("VFIFO offset of group %0d wrapped past its maximum", g);
		end
	endgenerate

endmodule

bind io_datapath_top io_datapath_properties props_i (
	.pll_afi_clk     (pll_afi_clk),
	.reset_n_afi_clk (reset_n_afi_clk),
	.mem_stable      (mem_stable),
	.afi_rdata_valid (afi_rdata_valid),
	.vfifo_ofs       (delay_i.vfifo_ofs)
);

// File: sim/io_datapath_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O datapath testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module io_datapath_tb;

	import phy_cfg_pkg::*;
	import phy_types_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 5;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_ROWS     = 8;
	localparam int MAX_CYCLES   = 256;
	localparam int WD_MARGIN    = 20;
	localparam int EXTRA_SHIFT  = 1;
	localparam int LANE_BITS    = NUM_GROUPS * $bits(group_write_t);
	localparam int OFS_LIMIT    = (1 << VFIFO_OFS_WIDTH) - 1;

	// One row of the stimulus table
	typedef struct packed {
		logic [LAT_WIDTH-1:0]  latency;
		logic [NUM_GROUPS-1:0] inc_mask;
		logic [3:0]            inc_pulses;
		logic                  mem_stable;
		logic [31:0]           strobe_pattern;
		logic [7:0]            cycles;
	} stim_row_t;

	logic                          pll_afi_clk;
	logic                          reset_n_afi_clk;
	afi_write_t                    afi_write;
	logic                          rdata_en_full;
	read_ctrl_t                    read_ctrl;
	logic                          mem_stable;
	group_write_t [NUM_GROUPS-1:0] write_lanes;
	logic [AFI_RATE_RATIO-1:0]     afi_rdata_valid;

	// Increment pulses go out on even row cycles, strobe pattern bit k on row cycle k
	stim_row_t stim_table [NUM_ROWS] = '{
		'{5'd0, 2'b00, 4'd0, 1'b1, 32'h0000_0000, 8'd6},
		'{5'd0, 2'b00, 4'd0, 1'b1, 32'h0000_0001, 8'd8},
		'{5'd5, 2'b00, 4'd0, 1'b1, 32'h0000_0007, 8'd14},
		'{5'd2, 2'b00, 4'd0, 1'b1, 32'h0000_0005, 8'd10},
		'{5'd0, 2'b01, 4'd1, 1'b1, 32'h0000_0030, 8'd12},
		'{5'd0, 2'b11, 4'd9, 1'b1, 32'h0010_0000, 8'd32},
		'{5'd0, 2'b00, 4'd0, 1'b0, 32'h0000_0004, 8'd10},
		'{5'd3, 2'b01, 4'd2, 1'b1, 32'h00F0_3C0F, 8'd40}
	};

	string row_name [NUM_ROWS] = '{
		"reset_idle",
		"single_strobe",
		"latency_five",
		"latency_two",
		"inc_one_group",
		"inc_nine_saturate",
		"stable_low_clear",
		"mixed_traffic"
	};

	// Reference model state
	logic                       strobe_hist [MAX_CYCLES];
	logic [VFIFO_OFS_WIDTH-1:0] model_ofs [NUM_GROUPS];
	logic                       expected_merge;
	afi_write_t                 prev_write;
	logic [31:0]                lcg_state;

	io_datapath_top #(
		.REGISTER_C2P      (1),
		.EXTRA_VFIFO_SHIFT (EXTRA_SHIFT)
	) dut_i (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_write       (afi_write),
		.rdata_en_full   (rdata_en_full),
		.read_ctrl       (read_ctrl),
		.mem_stable      (mem_stable),
		.write_lanes     (write_lanes),
		.afi_rdata_valid (afi_rdata_valid)
	);

	initial begin
		pll_afi_clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Walks the AFI bus bit by bit and drops each bit into its lane
	function automatic logic [LANE_BITS-1:0] regroup_write(input afi_write_t w);
		group_write_t [NUM_GROUPS-1:0] lanes;
		int slice;
		int s;
		int g;

		lanes = '0;
		for (int b = 0; b < AFI_DQ_WIDTH; b++) begin
			slice = b / DQ_PER_GROUP;
			s = slice / NUM_GROUPS;
			g = slice % NUM_GROUPS;
			lanes[g].dq_slots[s][b % DQ_PER_GROUP] = w.dq[b];
		end
		for (int b = 0; b < AFI_DM_WIDTH; b++) begin
			slice = b / DM_PER_GROUP;
			s = slice / NUM_GROUPS;
			g = slice % NUM_GROUPS;
			lanes[g].dm_slots[s][b % DM_PER_GROUP] = w.wrdata_mask[b];
		end
		for (int e = 0; e < AFI_EN_WIDTH; e++) begin
			s = e / NUM_GROUPS;
			g = e % NUM_GROUPS;
			lanes[g].oe[s] = {DQ_PER_GROUP{w.wrdata_en[e]}};
			lanes[g].dqs_en[s] = w.dqs_en[e];
			lanes[g].oct_ena[s] = w.oct_ena[e];
		end
		return lanes;
	endfunction

	task automatic check_value(input string name, input logic [LANE_BITS-1:0] expected,
			input logic [LANE_BITS-1:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s: expected %h, actual %h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "Value mismatch in %s", name);
		end
	endtask

	task automatic drive_random_write();
		logic [95:0] word;

		for (int i = 0; i < 3; i++) begin
			lcg_state = lcg_next(lcg_state);
			word[i*32 +: 32] = lcg_state;
		end
		afi_write = word[$bits(afi_write_t)-1:0];
	endtask

	task automatic drive_row_cycle(input stim_row_t row, input int k);
		read_ctrl.latency = row.latency;
		if (k % 2 == 0 && k / 2 < int'(row.inc_pulses)) begin
			read_ctrl.inc_vfifo = row.inc_mask;
		end else begin
			read_ctrl.inc_vfifo = '0;
		end
		mem_stable = row.mem_stable;
		rdata_en_full = (k < 32) ? row.strobe_pattern[k] : 1'b0;
		drive_random_write();
	endtask

	// Valid leaves the DUT 2 + shift + latency + offset cycles after the strobe
	// The value computed here is compared one cycle after this update
	task automatic update_model(input int cycle);
		int idx;
		logic merged;

		merged = 1'b1;
		strobe_hist[cycle] = rdata_en_full;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			idx = cycle + 1 - (2 + EXTRA_SHIFT + int'(read_ctrl.latency)
				+ int'(model_ofs[g]));
			if (idx < 0) begin
				merged = 1'b0;
			end else if (!strobe_hist[idx]) begin
				merged = 1'b0;
			end
		end
		expected_merge = merged;

		for (int g = 0; g < NUM_GROUPS; g++) begin
			if (!mem_stable) begin
				model_ofs[g] = '0;
			end else if (read_ctrl.inc_vfifo[g] && int'(model_ofs[g]) != OFS_LIMIT) begin
				model_ofs[g] = model_ofs[g] + 1'b1;
			end
		end
		prev_write = afi_write;
	endtask

	initial begin
		int total;

		total = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			total += int'(stim_table[r].cycles);
		end
		#((RESET_CYCLES + total + WD_MARGIN) * CLK_PERIOD);
		$display("Timeout: the stimulus table did not complete in the expected time");
		$display("TESTBENCH FAILED");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		int cycle;

		reset_n_afi_clk = 1'b0;
		afi_write = '0;
		rdata_en_full = 1'b0;
		read_ctrl = '0;
		mem_stable = 1'b0;
		lcg_state = 32'h1404_da8f;
		expected_merge = 1'b0;
		prev_write = '0;
		cycle = 0;
		for (int i = 0; i < MAX_CYCLES; i++) begin
			strobe_hist[i] = 1'b0;
		end
		for (int g = 0; g < NUM_GROUPS; g++) begin
			model_ofs[g] = '0;
		end

		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		#DRIVE_DELAY reset_n_afi_clk = 1'b1;

		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int k = 0; k < int'(stim_table[r].cycles); k++) begin
				@(posedge pll_afi_clk);
				#1;
				check_value({row_name[r], " afi_rdata_valid"},
					LANE_BITS'({AFI_RATE_RATIO{expected_merge}}), LANE_BITS'(afi_rdata_valid));
				check_value({row_name[r], " write_lanes"}, regroup_write(prev_write),
					write_lanes);
				#(DRIVE_DELAY - 1);
				drive_row_cycle(stim_table[r], k);
				update_model(cycle);
				cycle++;
			end
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: project.f
source/phy_cfg_pkg.sv
source/phy_types_pkg.sv
source/write_lane_decode.sv
source/read_valid_delay.sv
source/read_valid_merge.sv
source/io_datapath_top.sv
sim/io_datapath_properties.sv
sim/io_datapath_tb.sv

// File: Makefile
TOP := io_datapath_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ns --top-module $(TOP) -f project.f
	verilator --lint-only --timescale 1ns/1ns --top-module io_datapath_top \
		source/phy_cfg_pkg.sv source/phy_types_pkg.sv source/write_lane_decode.sv \
		source/read_valid_delay.sv source/read_valid_merge.sv source/io_datapath_top.sv

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module $(TOP) \
		-f project.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
